// ==== src/rfid_cfg_pkg.sv ====
// configuration encoding of the reader front end
// command opcodes, major modes and configuration word fields
`default_nettype none

package rfid_cfg_pkg;

	// ------------------------------------------------------------
	// command word layout
	// ------------------------------------------------------------

	// a command is 16 bits, with the opcode in the top nibble and data in the low byte
	localparam int cmd_word_bits = 16;
	localparam int cmd_op_lsb = 12;
	localparam int cmd_data_bits = 8;

	// only two opcodes do anything, the rest are dropped by the receiver
	typedef enum logic [3:0] {
		conf_op_write_conf = 4'd1,
		conf_op_write_divisor = 4'd2
	} conf_op_t;

	// ------------------------------------------------------------
	// configuration word layout
	// ------------------------------------------------------------

	// the major mode sits in the top three bits of the configuration word
	localparam int conf_mode_lsb = 5;
	localparam int conf_lf_125khz_bit = 3;
	localparam int conf_hf_shallow_bit = 0;

	// only lf_read and hf_tx have an engine behind them in this design
	typedef enum logic [2:0] {
		mode_lf_read = 3'd0,
		mode_lf_sim = 3'd1,
		mode_hf_tx = 3'd2,
		mode_hf_rx = 3'd3,
		mode_hf_sim = 3'd4,
		mode_hf_14443a = 3'd5,
		mode_unused = 3'd6,
		mode_off = 3'd7
	} major_mode_t;

	// mode bits all ones, so the front end wakes up with every pin off
	localparam logic [7:0] conf_reset_word = 8'hE0;
	localparam logic [7:0] divisor_reset = 8'd0;

endpackage

`default_nettype wire

// ==== src/rfid_io_pkg.sv ====
// pin and serial link layout of the reader front end
`default_nettype none

package rfid_io_pkg;

	// one A/D sample per serial burst, shifted out MSB first
	localparam int ssp_sample_bits = 8;
	localparam int ssp_cnt_bits = $clog2(ssp_sample_bits);
	localparam logic [ssp_cnt_bits-1:0] ssp_last_bit = ssp_cnt_bits'(ssp_sample_bits - 1);

	// divisor that gives the 125 kHz antenna clock
	localparam logic [7:0] lf_125khz_divisor = 8'd95;

	// strobe spacing of the hf return path, both powers of two
	localparam int hf_ssp_clk_period = 8;
	localparam int hf_ssp_frame_period = 64;
	localparam int hf_cnt_bits = $clog2(hf_ssp_frame_period);
	localparam logic [hf_cnt_bits-1:0] hf_clk_mask = hf_cnt_bits'(hf_ssp_clk_period - 1);

	// antenna, A/D clock and serial pins driven by each engine
	localparam int pin_count = 10;

endpackage

`default_nettype wire

// ==== src/conf_receiver.sv ====
// configuration receiver
// shifts in 16-bit command words and holds the configuration word and divisor
`default_nettype none

module conf_receiver (
	input wire ncs,
	input wire rst_n,
	input wire mosi,
	input wire spi_bit,
	input wire spi_end,
	output rfid_cfg_pkg::major_mode_t major_mode,
	output logic [7:0] divisor,
	output logic lf_use_125khz,
	output logic hf_shallow
);

	logic [rfid_cfg_pkg::cmd_word_bits-1:0] shift_q;
	logic [rfid_cfg_pkg::cmd_data_bits-1:0] conf_q;
	rfid_cfg_pkg::conf_op_t op;

	// the host sends MSB first, so each new bit enters at the bottom
	always_ff @(posedge ncs)
	begin
		if (spi_bit)
		begin
			shift_q <= {shift_q[rfid_cfg_pkg::cmd_word_bits-2:0], mosi};
		end
	end

	// the opcode is whatever sits in the top nibble when the word closes
	assign op = rfid_cfg_pkg::conf_op_t'(
		shift_q[rfid_cfg_pkg::cmd_word_bits-1:rfid_cfg_pkg::cmd_op_lsb]);

	// ------------------------------------------------------------
	// decode on end of word
	// ------------------------------------------------------------

	// unknown opcodes leave both registers as they were
	always_ff @(posedge ncs)
	begin
		if (!rst_n)
		begin
			conf_q <= rfid_cfg_pkg::conf_reset_word;
			divisor <= rfid_cfg_pkg::divisor_reset;
		end
		else if (spi_end)
		begin
			case (op)
				rfid_cfg_pkg::conf_op_write_conf:
				begin
					conf_q <= shift_q[rfid_cfg_pkg::cmd_data_bits-1:0];
				end
				rfid_cfg_pkg::conf_op_write_divisor:
				begin
					divisor <= shift_q[rfid_cfg_pkg::cmd_data_bits-1:0];
				end
				default:
				begin
					conf_q <= conf_q;
				end
			endcase
		end
	end

	// field views of the held word, all straight from the register
	assign major_mode = rfid_cfg_pkg::major_mode_t'(
		conf_q[rfid_cfg_pkg::cmd_data_bits-1:rfid_cfg_pkg::conf_mode_lsb]);
	assign lf_use_125khz = conf_q[rfid_cfg_pkg::conf_lf_125khz_bit];
	assign hf_shallow = conf_q[rfid_cfg_pkg::conf_hf_shallow_bit];

endmodule

`default_nettype wire

// ==== src/lf_reader.sv ====
// low-frequency reader engine
// divides the clock for the antenna and A/D, captures samples on rising
// A/D clock ticks and sends each one out as a framed serial burst
`default_nettype none

module lf_reader (
	input wire ncs,
	input wire rst_n,
	input wire [7:0] divisor,
	input wire use_125khz,
	input wire [7:0] adc_d,
	output logic pwr_lo,
	output logic pwr_hi,
	output logic pwr_oe1,
	output logic pwr_oe2,
	output logic pwr_oe3,
	output logic pwr_oe4,
	output logic adc_clk,
	output logic ssp_frame,
	output logic ssp_din,
	output logic ssp_clk
);

	logic [7:0] div_eff;
	logic [7:0] div_cnt;
	logic tick;
	logic adc_clk_q;
	logic capture;
	logic [rfid_io_pkg::ssp_sample_bits-1:0] hold_q;
	logic hold_valid;
	logic [rfid_io_pkg::ssp_sample_bits-1:0] shift_q;
	logic [rfid_io_pkg::ssp_cnt_bits-1:0] bit_cnt;
	logic busy;
	logic last_bit;
	logic start;

	// ------------------------------------------------------------
	// clock divider
	// ------------------------------------------------------------

	// the 125 kHz flag overrides whatever divisor the host wrote
	assign div_eff = use_125khz ? rfid_io_pkg::lf_125khz_divisor : divisor;
	assign tick = (div_cnt == '0);

	// counting D down to zero takes D+1 cycles, one half period of adc_clk
	always_ff @(posedge ncs)
	begin
		if (!rst_n)
		begin
			div_cnt <= '0;
			adc_clk_q <= 1'b0;
		end
		else if (tick)
		begin
			div_cnt <= div_eff;
			adc_clk_q <= !adc_clk_q;
		end
		else
		begin
			div_cnt <= div_cnt - 1'b1;
		end
	end

	// ------------------------------------------------------------
	// sample capture and serializer
	// ------------------------------------------------------------

	// adc_d is taken on the tick that drives adc_clk high
	assign capture = tick && !adc_clk_q;
	assign last_bit = busy && (bit_cnt == rfid_io_pkg::ssp_last_bit);
	// a waiting sample may follow the last bit of a burst back to back
	assign start = hold_valid && (!busy || last_bit);

	// one entry only, so a newer capture simply replaces a waiting one
	always_ff @(posedge ncs)
	begin
		if (capture)
		begin
			hold_q <= adc_d;
		end
	end

	// a capture in the same cycle as a start keeps the slot full
	always_ff @(posedge ncs)
	begin
		if (!rst_n)
		begin
			hold_valid <= 1'b0;
		end
		else if (capture)
		begin
			hold_valid <= 1'b1;
		end
		else if (start)
		begin
			hold_valid <= 1'b0;
		end
	end

	// the shifter runs empty after eight bits, which keeps ssp_din low when idle
	always_ff @(posedge ncs)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			bit_cnt <= '0;
			shift_q <= '0;
		end
		else if (start)
		begin
			busy <= 1'b1;
			bit_cnt <= '0;
			shift_q <= hold_q;
		end
		else if (busy)
		begin
			bit_cnt <= bit_cnt + 1'b1;
			shift_q <= {shift_q[rfid_io_pkg::ssp_sample_bits-2:0], 1'b0};
			if (last_bit)
			begin
				busy <= 1'b0;
			end
		end
	end

	// reader only listens, so the carrier drivers stay off
	assign adc_clk = adc_clk_q;
	assign pwr_lo = adc_clk_q;
	assign pwr_hi = 1'b0;
	assign pwr_oe1 = 1'b0;
	assign pwr_oe2 = 1'b0;
	assign pwr_oe3 = 1'b0;
	assign pwr_oe4 = 1'b0;

	// one ssp_clk strobe per bit, frame marks the MSB
	assign ssp_clk = busy;
	assign ssp_din = shift_q[rfid_io_pkg::ssp_sample_bits-1];
	assign ssp_frame = busy && (bit_cnt == '0);

endmodule

`default_nettype wire

// ==== src/hf_reader_tx.sv ====
// high-frequency reader transmit engine
// gates the carrier with the host modulation bit and returns the comparator bit
`default_nettype none

module hf_reader_tx (
	input wire ncs,
	input wire rst_n,
	input wire shallow,
	input wire ssp_dout,
	input wire cross_hi,
	output logic pwr_lo,
	output logic pwr_hi,
	output logic pwr_oe1,
	output logic pwr_oe2,
	output logic pwr_oe3,
	output logic pwr_oe4,
	output logic adc_clk,
	output logic ssp_frame,
	output logic ssp_din,
	output logic ssp_clk
);

	logic carrier_q;
	logic dout_q;
	logic cross_q;
	logic [rfid_io_pkg::hf_cnt_bits-1:0] phase_q;

	// carrier at half the system clock, host pins taken in once
	always_ff @(posedge ncs)
	begin
		if (!rst_n)
		begin
			carrier_q <= 1'b0;
			dout_q <= 1'b0;
			cross_q <= 1'b0;
			phase_q <= '0;
		end
		else
		begin
			carrier_q <= !carrier_q;
			dout_q <= ssp_dout;
			cross_q <= cross_hi;
			phase_q <= phase_q + 1'b1;
		end
	end

	// ------------------------------------------------------------
	// antenna side
	// ------------------------------------------------------------

	// a high modulation bit kills the carrier for the whole bit time
	assign pwr_hi = carrier_q && !dout_q;
	// shallow modulation also detunes through the fourth driver enable
	assign pwr_oe4 = shallow && dout_q;
	assign pwr_lo = 1'b0;
	assign pwr_oe1 = 1'b0;
	assign pwr_oe2 = 1'b0;
	assign pwr_oe3 = 1'b0;
	assign adc_clk = carrier_q;

	// strobes fire at the top of the count, so nothing pulses right after reset
	assign ssp_din = cross_q;
	assign ssp_clk = ((phase_q & rfid_io_pkg::hf_clk_mask) == rfid_io_pkg::hf_clk_mask);
	assign ssp_frame = (phase_q == '1);

endmodule

`default_nettype wire

// ==== src/pin_mux.sv ====
// output pin multiplexer
// registers the selected engine's pins, all low in modes without an engine
`default_nettype none

module pin_mux (
	input wire ncs,
	input wire rst_n,
	input wire rfid_cfg_pkg::major_mode_t major_mode,
	input wire lf_pwr_lo,
	input wire lf_pwr_hi,
	input wire lf_pwr_oe1,
	input wire lf_pwr_oe2,
	input wire lf_pwr_oe3,
	input wire lf_pwr_oe4,
	input wire lf_adc_clk,
	input wire lf_ssp_frame,
	input wire lf_ssp_din,
	input wire lf_ssp_clk,
	input wire hf_pwr_lo,
	input wire hf_pwr_hi,
	input wire hf_pwr_oe1,
	input wire hf_pwr_oe2,
	input wire hf_pwr_oe3,
	input wire hf_pwr_oe4,
	input wire hf_adc_clk,
	input wire hf_ssp_frame,
	input wire hf_ssp_din,
	input wire hf_ssp_clk,
	output logic pwr_lo,
	output logic pwr_hi,
	output logic pwr_oe1,
	output logic pwr_oe2,
	output logic pwr_oe3,
	output logic pwr_oe4,
	output logic adc_clk,
	output logic ssp_frame,
	output logic ssp_din,
	output logic ssp_clk
);

	logic [rfid_io_pkg::pin_count-1:0] lf_pins;
	logic [rfid_io_pkg::pin_count-1:0] hf_pins;
	logic [rfid_io_pkg::pin_count-1:0] pins_q;

	// same pin order for both engines and the outputs
	assign lf_pins = {lf_pwr_lo, lf_pwr_hi, lf_pwr_oe1, lf_pwr_oe2, lf_pwr_oe3,
		lf_pwr_oe4, lf_adc_clk, lf_ssp_frame, lf_ssp_din, lf_ssp_clk};
	assign hf_pins = {hf_pwr_lo, hf_pwr_hi, hf_pwr_oe1, hf_pwr_oe2, hf_pwr_oe3,
		hf_pwr_oe4, hf_adc_clk, hf_ssp_frame, hf_ssp_din, hf_ssp_clk};

	// the register hides the mode decode, so a switch cannot leave a runt on the drivers
	always_ff @(posedge ncs)
	begin
		if (!rst_n)
		begin
			pins_q <= '0;
		end
		else
		begin
			case (major_mode)
				rfid_cfg_pkg::mode_lf_read: pins_q <= lf_pins;
				rfid_cfg_pkg::mode_hf_tx: pins_q <= hf_pins;
				// off, unused and the modes without an engine here
				default: pins_q <= '0;
			endcase
		end
	end

	assign {pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3,
		pwr_oe4, adc_clk, ssp_frame, ssp_din, ssp_clk} = pins_q;

endmodule

`default_nettype wire

// ==== src/rfid_frontend.sv ====
// reader front end top level
// configuration receiver, lf and hf engines and the registered pin multiplexer
`default_nettype none

module rfid_frontend (
	input wire ncs,
	input wire rst_n,
	input wire mosi,
	input wire spi_bit,
	input wire spi_end,
	input wire [7:0] adc_d,
	input wire ssp_dout,
	input wire cross_hi,
	output logic pwr_lo,
	output logic pwr_hi,
	output logic pwr_oe1,
	output logic pwr_oe2,
	output logic pwr_oe3,
	output logic pwr_oe4,
	output logic adc_clk,
	output logic ssp_frame,
	output logic ssp_din,
	output logic ssp_clk
);

	rfid_cfg_pkg::major_mode_t major_mode;
	logic [7:0] divisor;
	logic lf_use_125khz;
	logic hf_shallow;

	// ------------------------------------------------------------
	// per engine pin sets
	// ------------------------------------------------------------
	logic lf_pwr_lo;
	logic lf_pwr_hi;
	logic lf_pwr_oe1;
	logic lf_pwr_oe2;
	logic lf_pwr_oe3;
	logic lf_pwr_oe4;
	logic lf_adc_clk;
	logic lf_ssp_frame;
	logic lf_ssp_din;
	logic lf_ssp_clk;
	logic hf_pwr_lo;
	logic hf_pwr_hi;
	logic hf_pwr_oe1;
	logic hf_pwr_oe2;
	logic hf_pwr_oe3;
	logic hf_pwr_oe4;
	logic hf_adc_clk;
	logic hf_ssp_frame;
	logic hf_ssp_din;
	logic hf_ssp_clk;

	conf_receiver u_conf_receiver (
		.ncs(ncs),
		.rst_n(rst_n),
		.mosi(mosi),
		.spi_bit(spi_bit),
		.spi_end(spi_end),
		.major_mode(major_mode),
		.divisor(divisor),
		.lf_use_125khz(lf_use_125khz),
		.hf_shallow(hf_shallow)
	);

	// both engines run all the time, the multiplexer picks one
	lf_reader u_lf_reader (
		.ncs(ncs),
		.rst_n(rst_n),
		.divisor(divisor),
		.use_125khz(lf_use_125khz),
		.adc_d(adc_d),
		.pwr_lo(lf_pwr_lo),
		.pwr_hi(lf_pwr_hi),
		.pwr_oe1(lf_pwr_oe1),
		.pwr_oe2(lf_pwr_oe2),
		.pwr_oe3(lf_pwr_oe3),
		.pwr_oe4(lf_pwr_oe4),
		.adc_clk(lf_adc_clk),
		.ssp_frame(lf_ssp_frame),
		.ssp_din(lf_ssp_din),
		.ssp_clk(lf_ssp_clk)
	);

	hf_reader_tx u_hf_reader_tx (
		.ncs(ncs),
		.rst_n(rst_n),
		.shallow(hf_shallow),
		.ssp_dout(ssp_dout),
		.cross_hi(cross_hi),
		.pwr_lo(hf_pwr_lo),
		.pwr_hi(hf_pwr_hi),
		.pwr_oe1(hf_pwr_oe1),
		.pwr_oe2(hf_pwr_oe2),
		.pwr_oe3(hf_pwr_oe3),
		.pwr_oe4(hf_pwr_oe4),
		.adc_clk(hf_adc_clk),
		.ssp_frame(hf_ssp_frame),
		.ssp_din(hf_ssp_din),
		.ssp_clk(hf_ssp_clk)
	);

	pin_mux u_pin_mux (
		.ncs(ncs),
		.rst_n(rst_n),
		.major_mode(major_mode),
		.lf_pwr_lo(lf_pwr_lo),
		.lf_pwr_hi(lf_pwr_hi),
		.lf_pwr_oe1(lf_pwr_oe1),
		.lf_pwr_oe2(lf_pwr_oe2),
		.lf_pwr_oe3(lf_pwr_oe3),
		.lf_pwr_oe4(lf_pwr_oe4),
		.lf_adc_clk(lf_adc_clk),
		.lf_ssp_frame(lf_ssp_frame),
		.lf_ssp_din(lf_ssp_din),
		.lf_ssp_clk(lf_ssp_clk),
		.hf_pwr_lo(hf_pwr_lo),
		.hf_pwr_hi(hf_pwr_hi),
		.hf_pwr_oe1(hf_pwr_oe1),
		.hf_pwr_oe2(hf_pwr_oe2),
		.hf_pwr_oe3(hf_pwr_oe3),
		.hf_pwr_oe4(hf_pwr_oe4),
		.hf_adc_clk(hf_adc_clk),
		.hf_ssp_frame(hf_ssp_frame),
		.hf_ssp_din(hf_ssp_din),
		.hf_ssp_clk(hf_ssp_clk),
		.pwr_lo(pwr_lo),
		.pwr_hi(pwr_hi),
		.pwr_oe1(pwr_oe1),
		.pwr_oe2(pwr_oe2),
		.pwr_oe3(pwr_oe3),
		.pwr_oe4(pwr_oe4),
		.adc_clk(adc_clk),
		.ssp_frame(ssp_frame),
		.ssp_din(ssp_din),
		.ssp_clk(ssp_clk)
	);

endmodule

`default_nettype wire

// ==== sim/rfid_frontend_tb.sv ====
// testbench for the reader front end
// reads test steps from a file, sends command words and checks the pins
`default_nettype none

module rfid_frontend_tb;

	localparam int kind_command = 0;
	localparam int kind_lf = 1;
	localparam int kind_hf = 2;
	localparam int max_steps = 64;

	logic ncs;
	logic rst_n;
	logic mosi;
	logic spi_bit;
	logic spi_end;
	logic [7:0] adc_d;
	logic ssp_dout;
	logic cross_hi;
	logic pwr_lo;
	logic pwr_hi;
	logic pwr_oe1;
	logic pwr_oe2;
	logic pwr_oe3;
	logic pwr_oe4;
	logic adc_clk;
	logic ssp_frame;
	logic ssp_din;
	logic ssp_clk;

	int step_kind [max_steps];
	logic [15:0] step_cmd [max_steps];
	logic [7:0] step_adc [max_steps];
	int step_half [max_steps];
	logic [7:0] step_byte [max_steps];
	int num_steps = 0;
	int errors = 0;
	int checks = 0;
	int i;
	logic steps_loaded = 1'b0;
	logic [31:0] rand_state = 32'd8;

	rfid_frontend u_rfid_frontend (
		.ncs(ncs),
		.rst_n(rst_n),
		.mosi(mosi),
		.spi_bit(spi_bit),
		.spi_end(spi_end),
		.adc_d(adc_d),
		.ssp_dout(ssp_dout),
		.cross_hi(cross_hi),
		.pwr_lo(pwr_lo),
		.pwr_hi(pwr_hi),
		.pwr_oe1(pwr_oe1),
		.pwr_oe2(pwr_oe2),
		.pwr_oe3(pwr_oe3),
		.pwr_oe4(pwr_oe4),
		.adc_clk(adc_clk),
		.ssp_frame(ssp_frame),
		.ssp_din(ssp_din),
		.ssp_clk(ssp_clk)
	);

	initial
	begin
		ncs = 1'b0;
		forever #4 ncs = !ncs;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------

	// 32-bit xorshift that feeds the hf modulation and comparator bits
	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got 0x%h, expected 0x%h", $time, name, got, exp);
			errors++;
		end
	endtask

	// sixteen bit strobes MSB first, then the end-of-word strobe
	task automatic send_command(input logic [15:0] word);
		int b;
		for (b = 15; b >= 0; b--)
		begin
			@(posedge ncs);
			mosi <= word[b];
			spi_bit <= 1'b1;
		end
		@(posedge ncs);
		spi_bit <= 1'b0;
		spi_end <= 1'b1;
		@(posedge ncs);
		spi_end <= 1'b0;
	endtask

	// lines starting with # are skipped, the rest hold one step each
	task automatic load_steps();
		int fd;
		int code;
		int h;
		logic [63:0] kind_buf;
		logic [8*200-1:0] skip_buf;
		logic [15:0] w;
		logic [7:0] a;
		logic [7:0] b;
		logic done;
		fd = $fopen("sim/rfid_tests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test file sim/rfid_tests.txt");
		end
		else
		begin
			done = 1'b0;
			while (!done)
			begin
				code = $fscanf(fd, "%s", kind_buf);
				if (code != 1)
				begin
					done = 1'b1;
				end
				else if (kind_buf == "#")
				begin
					code = $fgets(skip_buf, fd);
				end
				else
				begin
					code = $fscanf(fd, "%h %h %d %h", w, a, h, b);
					if (code != 4 || num_steps >= max_steps)
					begin
						$display("test line after step %0d is malformed or surplus", num_steps);
						errors++;
						done = 1'b1;
					end
					else if (kind_buf != "command" && kind_buf != "lf" && kind_buf != "hf")
					begin
						$display("test line after step %0d has an unknown step kind", num_steps);
						errors++;
					end
					else
					begin
						step_kind[num_steps] = (kind_buf == "command") ? kind_command :
							(kind_buf == "lf") ? kind_lf : kind_hf;
						step_cmd[num_steps] = w;
						step_adc[num_steps] = a;
						step_half[num_steps] = h;
						step_byte[num_steps] = b;
						num_steps++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ------------------------------------------------------------
	// per step observation
	// ------------------------------------------------------------

	// starts on the cycle where the new mode reaches the pins
	// checks at the falling edge, drives hf inputs at the rising edge
	task automatic observe_step(input int kind, input logic shallow, input int half,
		input logic [7:0] exp_byte);
		int n;
		int cyc;
		int last_rise;
		int rises;
		int last_clk;
		int last_frame;
		int frames;
		int strobes;
		int bursts;
		logic prev_adc;
		logic [7:0] got;
		logic [2:0] dh;
		logic [2:0] ch;
		n = (half == 0) ? 200 : 8 * half + 200;
		last_rise = -1;
		rises = 0;
		last_clk = -1;
		last_frame = -1;
		frames = 0;
		strobes = -1;
		bursts = 0;
		got = '0;
		// a rise right at the switch is not a clean reference
		prev_adc = 1'b1;
		// inputs were held during the command, so the history is flat
		dh = {3{ssp_dout}};
		ch = {3{cross_hi}};
		for (cyc = 0; cyc < n; cyc++)
		begin
			@(negedge ncs);
			if (kind == kind_command)
			begin
				compare_value("output pins", {pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3,
					pwr_oe4, adc_clk, ssp_frame, ssp_din, ssp_clk}, 0);
			end
			else
			begin
				if (adc_clk && !prev_adc)
				begin
					if (last_rise >= 0)
						compare_value("adc_clk period", cyc - last_rise, 2 * half);
					last_rise = cyc;
					rises++;
				end
				prev_adc = adc_clk;
				if (ssp_frame)
					compare_value("ssp_clk at ssp_frame", ssp_clk, 1);
			end
			if (kind == kind_lf)
			begin
				compare_value("pwr_lo", pwr_lo, adc_clk);
				// the hf engine must not leak onto the drivers
				compare_value("pwr_hi and pwr_oe1..4", {pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3,
					pwr_oe4}, 0);
				if (ssp_clk && ssp_frame)
				begin
					if (strobes >= 0)
						compare_value("ssp_clk per burst", strobes, rfid_io_pkg::ssp_sample_bits);
					got = {7'b0, ssp_din};
					strobes = 1;
				end
				else if (ssp_clk && strobes >= 0)
				begin
					got = {got[6:0], ssp_din};
					strobes++;
				end
				// the first burst may still carry an older sample
				if (ssp_clk && strobes == rfid_io_pkg::ssp_sample_bits)
				begin
					bursts++;
					if (bursts > 1)
						compare_value("ssp_din burst", got, exp_byte);
				end
			end
			if (kind == kind_hf)
			begin
				compare_value("pwr_lo and pwr_oe1..3", {pwr_lo, pwr_oe1, pwr_oe2, pwr_oe3}, 0);
				// dh[2] and ch[2] were driven two rising edges ago
				// with the modulation bit low the antenna carries the carrier seen on adc_clk
				if (dh[2])
					compare_value("pwr_hi", pwr_hi, 0);
				else
					compare_value("pwr_hi", pwr_hi, adc_clk);
				compare_value("pwr_oe4", pwr_oe4, shallow && dh[2]);
				compare_value("ssp_din", ssp_din, ch[2]);
				if (ssp_clk)
				begin
					if (last_clk >= 0)
						compare_value("ssp_clk spacing", cyc - last_clk,
							rfid_io_pkg::hf_ssp_clk_period);
					last_clk = cyc;
				end
				if (ssp_frame)
				begin
					if (last_frame >= 0)
						compare_value("ssp_frame spacing", cyc - last_frame,
							rfid_io_pkg::hf_ssp_frame_period);
					last_frame = cyc;
					frames++;
				end
			end
			@(posedge ncs);
			if (kind == kind_hf)
			begin
				rand_state = next_random(rand_state);
				ssp_dout <= rand_state[0];
				cross_hi <= rand_state[1];
				dh = {dh[1:0], rand_state[0]};
				ch = {ch[1:0], rand_state[1]};
			end
		end
		if (kind != kind_command && rises < 2)
		begin
			$display("adc_clk did not rise twice during step of kind %0d", kind);
			errors++;
		end
		if (kind == kind_lf && bursts < 2)
		begin
			$display("fewer than two complete serial bursts were seen in an lf step");
			errors++;
		end
		if (kind == kind_hf && frames < 2)
		begin
			$display("fewer than two ssp_frame strobes were seen in an hf step");
			errors++;
		end
	endtask

	// ------------------------------------------------------------
	// main sequence and watchdog
	// ------------------------------------------------------------

	initial
	begin
		rst_n = 1'b0;
		mosi = 1'b0;
		spi_bit = 1'b0;
		spi_end = 1'b0;
		adc_d = 8'h00;
		ssp_dout = 1'b0;
		cross_hi = 1'b0;
		load_steps();
		repeat (16) @(posedge ncs);
		rst_n <= 1'b1;
		if (num_steps == 0)
		begin
			$display("no test steps could be read, nothing was run");
			errors++;
		end
		else
		begin
			steps_loaded = 1'b1;
			@(posedge ncs);
			// reset leaves the front end in the off mode
			observe_step(kind_command, 1'b0, 0, 8'h00);
			for (i = 0; i < num_steps; i++)
			begin
				@(posedge ncs);
				adc_d <= step_adc[i];
				send_command(step_cmd[i]);
				@(posedge ncs);
				observe_step(step_kind[i], step_cmd[i][rfid_cfg_pkg::conf_hf_shallow_bit],
					step_half[i], step_byte[i]);
			end
		end
		$display("steps %0d, checks %0d, errors %0d", num_steps, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// every step is far shorter than 2000 cycles
	initial
	begin
		wait (steps_loaded);
		repeat (num_steps * 2000 + 1000) @(posedge ncs);
		$display("the run timed out before all test steps finished");
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/rfid_tests.txt ====
# kind  cmd(hex)  adc_d(hex)  half(dec)  byte(hex)
# half is the expected adc_clk half period in cycles, 0 means every pin stays low
command 10E0 00 0  00
command 2004 00 0  00
lf      1000 A5 5  A5
lf      2009 3C 10 3C
lf      3055 96 10 96
lf      1008 5A 96 5A
hf      1040 00 1  00
hf      1041 00 1  00
lf      1000 C3 10 C3
hf      1040 00 1  00
command 10C0 00 0  00
command 4012 00 0  00
hf      1041 00 1  00
command 10E0 00 0  00
command 2001 00 0  00
lf      1000 81 2  81
lf      2000 7E 1  7E
command 10E0 00 0  00

// ==== sim.f ====
src/rfid_cfg_pkg.sv
src/rfid_io_pkg.sv
src/conf_receiver.sv
src/lf_reader.sv
src/hf_reader_tx.sv
src/pin_mux.sv
src/rfid_frontend.sv
sim/rfid_frontend_tb.sv

// ==== Bender.yml ====
package:
  name: rfid_frontend

sources:
  - src/rfid_cfg_pkg.sv
  - src/rfid_io_pkg.sv
  - src/conf_receiver.sv
  - src/lf_reader.sv
  - src/hf_reader_tx.sv
  - src/pin_mux.sv
  - src/rfid_frontend.sv
  - target: test
    files:
      - sim/rfid_frontend_tb.sv
